/* verilog.f */
+incdir+.
nn_pkg.sv
forward_layer.sv
error_calc.sv
weight_store.sv
train_ctrl.sv
nn_trainer.sv
nn_properties.sv
tb_nn_trainer.sv

/* Bender.yml */
package:
  name: nn_trainer

sources:
  - include_dirs:
      - .
    files:
      - nn_pkg.sv
      - forward_layer.sv
      - error_calc.sv
      - weight_store.sv
      - train_ctrl.sv
      - nn_trainer.sv
  - target: test
    include_dirs:
      - .
    files:
      - nn_properties.sv
      - tb_nn_trainer.sv

/* tb_nn_trainer.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module tb_nn_trainer import nn_pkg::*; ();

    localparam int N     = `NN_NEURONS;
    localparam int DEPTH = N * N;
    localparam int AW    = `NN_ADDR_WIDTH;
    localparam int NT    = 7;
    localparam int LIMIT = 4 * DEPTH + 32;

    typedef enum int {W_KEEP, W_IDENT, W_LARGE, W_RAND} wmode_t;

    logic          clk;
    logic          rst_n;
    logic          sample_valid;
    train_op_t     op;
    fix_vec_t      x;
    fix_vec_t      y;
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    fix_t          wr_data;
    logic [AW-1:0] rd_addr;
    fix_t          rd_data;
    fix_vec_t      result;
    fix_vec_t      error;
    logic          busy;
    logic          done;

    fix_t        model_w [DEPTH] = '{default: '0};
    logic [15:0] lfsr;
    int          errors;
    int          failed;
    int          done_cnt = 0;

    ////////////////////
    // Stimulus table, one row per test
    // Vectors are {elem3, elem2, elem1, elem0} in Q8.8
    // Rows flagged in t_rand take LFSR values instead
    string     t_name  [NT] = '{"ident_infer", "ident_train", "rand_train", "rand_infer",
                                "sat_infer", "sat_train", "busy_drop"};
    train_op_t t_op    [NT] = '{OP_INFER, OP_TRAIN, OP_TRAIN, OP_INFER,
                                OP_INFER, OP_TRAIN, OP_TRAIN};
    wmode_t    t_wmode [NT] = '{W_IDENT, W_KEEP, W_RAND, W_KEEP, W_LARGE, W_KEEP, W_RAND};
    bit        t_rand  [NT] = '{0, 0, 1, 1, 0, 0, 1};
    bit        t_poke  [NT] = '{0, 0, 0, 0, 0, 0, 1};
    fix_vec_t  t_x     [NT] = '{64'h0080_0200_FE80_0100, 64'h0040_FF00_0180_0200, 64'h0,
                                64'h0, 64'h7FFF_7FFF_7FFF_7FFF, 64'h8000_8000_8000_8000, 64'h0};
    fix_vec_t  t_y     [NT] = '{64'h0100_0200_FF00_0180, 64'h0000_0100_0300_FE00, 64'h0,
                                64'h0, 64'h8000_8000_8000_8000, 64'h7FFF_7FFF_7FFF_7FFF, 64'h0};

    nn_trainer i_nn_trainer (.*);

    bind nn_trainer nn_properties i_nn_properties (.clk, .rst_n, .busy, .done, .wr_en);

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (done) begin
            done_cnt++;
        end
    end

    ////////////////////
    // Reference model

    function automatic fix_t sat_model(input longint v);
        longint lim;
        lim = longint'(1) << (`NN_WIDTH - 1);
        if (v >= lim) begin
            return fix_t'(lim - 1);
        end
        if (v < -lim) begin
            return fix_t'(-lim);
        end
        return fix_t'(v);
    endfunction

    // Each product is scaled before it is summed
    function automatic fix_vec_t model_forward(input fix_vec_t xv);
        fix_vec_t r;
        longint   acc;
        for (int n = 0; n < N; n++) begin
            acc = 0;
            for (int i = 0; i < N; i++) begin
                acc += (longint'(xv[i]) * longint'(model_w[n * N + i])) >>> `NN_FRAC;
            end
            r[n] = sat_model(acc);
        end
        return r;
    endfunction

    task automatic model_update(input fix_vec_t xv, input fix_vec_t ev);
        longint change;
        for (int a = 0; a < DEPTH; a++) begin
            change = (longint'(ev[a / N]) * longint'(xv[a % N])) >>> (`NN_FRAC + `NN_RATE_SHIFT);
            model_w[a] = sat_model(longint'(model_w[a]) + change);
        end
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic rand_fix(input int nbits, output fix_t v);
        int raw;
        raw = 0;
        for (int k = 0; k < nbits; k++) begin
            raw = raw | (int'(lfsr[0]) << k);
            lfsr = lfsr_next(lfsr);
        end
        if (raw >= (1 << (nbits - 1))) begin
            raw = raw - (1 << nbits);
        end
        v = fix_t'(raw);
    endtask

    ////////////////////
    // Checks and bus tasks

    task automatic check_fix(input string name, input fix_t exp, input fix_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_vec(input string name, input fix_vec_t exp, input fix_vec_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic load_weights(input wmode_t mode);
        fix_t v;
        if (mode == W_KEEP) begin
            return;
        end
        for (int a = 0; a < DEPTH; a++) begin
            case (mode)
                // 1.5 on the diagonal
                W_IDENT: v = (a / N == a % N) ? fix_t'(384) : fix_t'(0);
                W_LARGE: v = FIX_MAX;
                default: rand_fix(10, v);
            endcase
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= AW'(a);
            wr_data <= v;
            model_w[a] = v;
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic verify_weights(input string name);
        for (int a = 0; a < DEPTH; a++) begin
            @(posedge clk);
            rd_addr <= AW'(a);
            @(negedge clk);
            check_fix($sformatf("%s weight %0d", name, a), model_w[a], rd_data);
        end
    endtask

    task automatic wait_busy(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!busy && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!busy) begin
            $display("%s: busy never rose within %0d cycles", name, LIMIT);
            errors++;
        end
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("%s: timed out waiting for done after %0d cycles", name, LIMIT);
            errors++;
        end
    endtask

    task automatic run_sample(input string name, input train_op_t o, input fix_vec_t xv,
                              input fix_vec_t yv, input bit poke);
        @(posedge clk);
        sample_valid <= 1'b1;
        op           <= o;
        x            <= xv;
        y            <= yv;
        @(posedge clk);
        sample_valid <= 1'b0;
        if (poke) begin
            // Second sample lands while the first is running
            wait_busy(name);
            @(posedge clk);
            sample_valid <= 1'b1;
            op           <= OP_INFER;
            x            <= ~xv;
            y            <= ~yv;
            @(posedge clk);
            sample_valid <= 1'b0;
        end
        wait_done(name);
    endtask

    initial begin
        fix_vec_t xv;
        fix_vec_t yv;
        fix_vec_t exp_res;
        fix_vec_t exp_err;
        fix_t     v;
        int       err_before;
        int       done_before;
        clk          = 1'b0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        op           = OP_INFER;
        x            = '0;
        y            = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        rd_addr      = '0;
        lfsr         = 16'd26;
        errors       = 0;
        failed       = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        verify_weights("reset");
        for (int t = 0; t < NT; t++) begin
            err_before  = errors;
            done_before = done_cnt;
            load_weights(t_wmode[t]);
            verify_weights(t_name[t]);
            xv = t_x[t];
            yv = t_y[t];
            for (int i = 0; i < N; i++) begin
                if (t_rand[t]) begin
                    rand_fix(12, v);
                    xv[i] = v;
                    rand_fix(12, v);
                    yv[i] = v;
                end
            end
            exp_res = model_forward(xv);
            for (int i = 0; i < N; i++) begin
                exp_err[i] = sat_model(longint'(yv[i]) - longint'(exp_res[i]));
            end
            if (t_op[t] == OP_TRAIN) begin
                model_update(xv, exp_err);
            end
            run_sample(t_name[t], t_op[t], xv, yv, t_poke[t]);
            check_vec({t_name[t], " result"}, exp_res, result);
            check_vec({t_name[t], " error"}, exp_err, error);
            verify_weights(t_name[t]);
            repeat (DEPTH + 8) @(negedge clk);
            if (done_cnt - done_before != 1) begin
                $display("%s: saw %0d done pulses where exactly one was expected", t_name[t],
                         done_cnt - done_before);
                errors++;
            end
            if (errors != err_before) begin
                failed++;
            end
            $display("%-12s %s", t_name[t], (errors == err_before) ? "ok" : "failed");
        end
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", NT, failed,
                 errors, i_nn_trainer.i_nn_properties.fails);
        if (errors == 0 && i_nn_trainer.i_nn_properties.fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* nn_properties.sv */
`timescale 1ns/1ps

module nn_properties (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic wr_en
);

    int fails = 0;

    ////////////////////
    // Strobes and levels

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fails++;
        end

    // busy falls together with done
    done_busy_low: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else begin
            $error("busy still high while done pulses");
            fails++;
        end

    no_write_busy: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !busy)
        else begin
            $error("weight write issued while the engine is busy");
            fails++;
        end

    busy_reset: assert property (@(posedge clk) !rst_n |=> !busy)
        else begin
            $error("busy high during reset");
            fails++;
        end

endmodule

/* nn_trainer.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module nn_trainer import nn_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sample_valid,
    input  train_op_t                 op,
    input  fix_vec_t                  x,
    input  fix_vec_t                  y,
    input  logic                      wr_en,
    input  logic [`NN_ADDR_WIDTH-1:0] wr_addr,
    input  fix_t                      wr_data,
    input  logic [`NN_ADDR_WIDTH-1:0] rd_addr,
    output fix_t                      rd_data,
    output fix_vec_t                  result,
    output fix_vec_t                  error,
    output logic                      busy,
    output logic                      done
);

    fix_vec_t                  x_q;
    fix_vec_t                  y_q;
    logic                      fwd_start;
    logic                      fwd_done;
    logic                      err_start;
    logic                      err_done;
    logic                      upd_start;
    logic                      upd_done;
    logic [`NN_ADDR_WIDTH-1:0] w_rd_addr;
    fix_t                      w_rd_data;

    train_ctrl i_train_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .op           (op),
        .x            (x),
        .y            (y),
        .fwd_done     (fwd_done),
        .err_done     (err_done),
        .upd_done     (upd_done),
        .x_q          (x_q),
        .y_q          (y_q),
        .fwd_start    (fwd_start),
        .err_start    (err_start),
        .upd_start    (upd_start),
        .busy         (busy),
        .done         (done)
    );

    forward_layer i_forward_layer (
        .clk       (clk),
        .rst_n     (rst_n),
        .fwd_start (fwd_start),
        .x         (x_q),
        .w_rd_data (w_rd_data),
        .w_rd_addr (w_rd_addr),
        .result    (result),
        .fwd_done  (fwd_done)
    );

    error_calc i_error_calc (
        .clk       (clk),
        .rst_n     (rst_n),
        .err_start (err_start),
        .result    (result),
        .y         (y_q),
        .error     (error),
        .err_done  (err_done)
    );

    weight_store i_weight_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .w_rd_addr (w_rd_addr),
        .upd_start (upd_start),
        .x_q       (x_q),
        .error     (error),
        .busy      (busy),
        .rd_data   (rd_data),
        .w_rd_data (w_rd_data),
        .upd_done  (upd_done)
    );

endmodule

/* train_ctrl.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module train_ctrl import nn_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sample_valid,
    input  train_op_t op,
    input  fix_vec_t  x,
    input  fix_vec_t  y,
    input  logic      fwd_done,
    input  logic      err_done,
    input  logic      upd_done,
    output fix_vec_t  x_q,
    output fix_vec_t  y_q,
    output logic      fwd_start,
    output logic      err_start,
    output logic      upd_start,
    output logic      busy,
    output logic      done
);

    ctrl_state_t state;
    train_op_t   op_q;
    logic        accept;

    // Samples arriving while busy are dropped
    assign accept = sample_valid && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op;
            x_q  <= x;
            y_q  <= y;
        end
    end

    ////////////////////
    // Sequencer

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            fwd_start <= 1'b0;
            err_start <= 1'b0;
            upd_start <= 1'b0;
        end else begin
            fwd_start <= 1'b0;
            err_start <= 1'b0;
            upd_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                IDLE, FINISH: begin
                    if (accept) begin
                        state     <= FORWARD;
                        busy      <= 1'b1;
                        fwd_start <= 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                FORWARD: begin
                    if (fwd_done) begin
                        state     <= ERROR;
                        err_start <= 1'b1;
                    end
                end
                ERROR: begin
                    if (err_done) begin
                        // Update only on a training sample
                        if (op_q == OP_TRAIN) begin
                            state     <= UPDATE;
                            upd_start <= 1'b1;
                        end else begin
                            state <= FINISH;
                            busy  <= 1'b0;
                            done  <= 1'b1;
                        end
                    end
                end
                UPDATE: begin
                    if (upd_done) begin
                        state <= FINISH;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* weight_store.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module weight_store import nn_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  logic [`NN_ADDR_WIDTH-1:0] wr_addr,
    input  fix_t                      wr_data,
    input  logic [`NN_ADDR_WIDTH-1:0] rd_addr,
    input  logic [`NN_ADDR_WIDTH-1:0] w_rd_addr,
    input  logic                      upd_start,
    input  fix_vec_t                  x_q,
    input  fix_vec_t                  error,
    input  logic                      busy,
    output fix_t                      rd_data,
    output fix_t                      w_rd_data,
    output logic                      upd_done
);

    localparam int DEPTH = `NN_NEURONS * `NN_NEURONS;
    localparam int AW    = `NN_ADDR_WIDTH;
    localparam int IW    = (`NN_NEURONS > 1) ? $clog2(`NN_NEURONS) : 1;
    localparam int SHIFT = `NN_FRAC + `NN_RATE_SHIFT;

    fix_t          mem [DEPTH];
    logic          upd_active;
    logic          upd_run;
    logic          upd_last;
    logic [AW-1:0] upd_addr;
    logic [IW-1:0] row;
    logic [IW-1:0] col;
    fix_t          err_sel;
    fix_t          x_sel;
    acc_t          change;
    fix_t          w_new;

    ////////////////////
    // Read ports

    assign rd_data   = mem[rd_addr];
    assign w_rd_data = mem[w_rd_addr];

    ////////////////////
    // Update datapath

    assign upd_run  = upd_start || upd_active;
    assign upd_last = (upd_addr == AW'(DEPTH - 1));

    // Address splits into neuron row and input column
    assign row = IW'(upd_addr / `NN_NEURONS);
    assign col = IW'(upd_addr % `NN_NEURONS);

    assign err_sel = error[row];
    assign x_sel   = x_q[col];

    // Delta times input, scaled by the learning rate
    assign change = (acc_t'(err_sel) * acc_t'(x_sel)) >>> SHIFT;
    assign w_new  = sat_fix(acc_t'(mem[upd_addr]) + change);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < DEPTH; a++) begin
                mem[a] <= '0;
            end
            upd_active <= 1'b0;
            upd_addr   <= '0;
            upd_done   <= 1'b0;
        end else begin
            upd_done <= 1'b0;
            if (upd_run) begin
                mem[upd_addr] <= w_new;
                if (upd_last) begin
                    upd_addr   <= '0;
                    upd_active <= 1'b0;
                    upd_done   <= 1'b1;
                end else begin
                    upd_addr   <= upd_addr + 1'b1;
                    upd_active <= 1'b1;
                end
            end else if (wr_en && !busy) begin
                // Load port, idle only
                mem[wr_addr] <= wr_data;
            end
        end
    end

endmodule

/* error_calc.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module error_calc import nn_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     err_start,
    input  fix_vec_t result,
    input  fix_vec_t y,
    output fix_vec_t error,
    output logic     err_done
);

    fix_vec_t err_next;

    // Target minus result per neuron
    // Linear activation, so the delta is the error itself
    always_comb begin
        for (int n = 0; n < `NN_NEURONS; n++) begin
            err_next[n] = sat_fix(acc_t'(y[n]) - acc_t'(result[n]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            error    <= '0;
            err_done <= 1'b0;
        end else begin
            err_done <= err_start;
            if (err_start) begin
                error <= err_next;
            end
        end
    end

endmodule

/* forward_layer.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module forward_layer import nn_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fwd_start,
    input  fix_vec_t                  x,
    input  fix_t                      w_rd_data,
    output logic [`NN_ADDR_WIDTH-1:0] w_rd_addr,
    output fix_vec_t                  result,
    output logic                      fwd_done
);

    localparam int AW = `NN_ADDR_WIDTH;
    localparam int IW = (`NN_NEURONS > 1) ? $clog2(`NN_NEURONS) : 1;

    logic          active;
    logic          run;
    logic          last_in;
    logic          last_neuron;
    logic [IW-1:0] n_cnt;
    logic [IW-1:0] i_cnt;
    fix_t          x_sel;
    acc_t          product;
    acc_t          acc;
    acc_t          acc_next;

    ////////////////////
    // Matrix walk

    // First element is taken on the start cycle itself
    assign run         = fwd_start || active;
    assign last_in     = (i_cnt == IW'(`NN_NEURONS - 1));
    assign last_neuron = (n_cnt == IW'(`NN_NEURONS - 1));

    // Row of neuron n_cnt, column of input i_cnt
    assign w_rd_addr = AW'(n_cnt * `NN_NEURONS + i_cnt);

    ////////////////////
    // Multiply-accumulate

    assign x_sel    = x[i_cnt];
    assign product  = (acc_t'(x_sel) * acc_t'(w_rd_data)) >>> `NN_FRAC;
    assign acc_next = acc + product;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            n_cnt    <= '0;
            i_cnt    <= '0;
            acc      <= '0;
            result   <= '0;
            fwd_done <= 1'b0;
        end else begin
            fwd_done <= 1'b0;
            if (run) begin
                if (last_in) begin
                    // Neuron complete
                    result[n_cnt] <= sat_fix(acc_next);
                    acc           <= '0;
                    i_cnt         <= '0;
                    if (last_neuron) begin
                        n_cnt    <= '0;
                        active   <= 1'b0;
                        fwd_done <= 1'b1;
                    end else begin
                        n_cnt  <= n_cnt + 1'b1;
                        active <= 1'b1;
                    end
                end else begin
                    acc    <= acc_next;
                    i_cnt  <= i_cnt + 1'b1;
                    active <= 1'b1;
                end
            end
        end
    end

endmodule

/* nn_pkg.sv */
`include "nn_cfg.svh"

package nn_pkg;

    typedef logic signed [`NN_WIDTH-1:0] fix_t;

    // Wide enough for a full row of products
    typedef logic signed [2*`NN_WIDTH+$clog2(`NN_NEURONS)-1:0] acc_t;

    // Element i belongs to neuron or input i
    typedef fix_t [`NN_NEURONS-1:0] fix_vec_t;

    typedef enum logic {
        OP_INFER,
        OP_TRAIN
    } train_op_t;

    typedef enum logic [2:0] {
        IDLE,
        FORWARD,
        ERROR,
        UPDATE,
        FINISH
    } ctrl_state_t;

    localparam fix_t FIX_MAX = {1'b0, {(`NN_WIDTH-1){1'b1}}};
    localparam fix_t FIX_MIN = {1'b1, {(`NN_WIDTH-1){1'b0}}};

    // Clamp a wide value to the fix_t range
    function automatic fix_t sat_fix(input acc_t v);
        if (v > acc_t'(FIX_MAX)) begin
            return FIX_MAX;
        end
        if (v < acc_t'(FIX_MIN)) begin
            return FIX_MIN;
        end
        return fix_t'(v);
    endfunction

endpackage

/* nn_cfg.svh */
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// Layer size, also the input vector length
`define NN_NEURONS 4

// Fixed-point word format
`define NN_WIDTH 16
`define NN_FRAC 8

// Learning rate as extra right shift of each weight change
`define NN_RATE_SHIFT 4

// One address per weight, NN_NEURONS squared entries
`define NN_ADDR_WIDTH ($clog2(`NN_NEURONS * `NN_NEURONS))

`endif
